// File: design/prbs_pkg.sv
package prbs_pkg;

    //////////////////////////////
    // tap format
    //////////////////////////////

    // tap slots per polynomial, unused slots hold zero
    localparam int TAP_COUNT = 4;

    // one tap position, 1-based bit index
    localparam int TAP_INDEX_W = 5;    // 0 = unused, 1..16 = bit

    //////////////////////////////
    // selects and counters
    //////////////////////////////

    localparam int POLY_SEL_W = 3;     // eight table entries

    // checker mismatch count, saturating
    localparam int ERR_CNT_W = 16;

    // steps between wraps, wide enough for 2^n - 1 up to n = 24
    localparam int PERIOD_W = 24;

endpackage : prbs_pkg

// File: design/shifter_lfsr.sv
`timescale 1ns/1ps

// generic xnor shift lfsr, taps chosen at run time
module shifter_lfsr #(
    parameter int WIDTH           = 16,  // register width
    parameter int TAP_INDEX_WIDTH = 5,   // bits per tap position
    parameter int TAP_COUNT       = 4    // tap slots
) (
    input  logic                                 i_clk,
    input  logic                                 i_rst_n,
    input  logic                                 i_enable,     // step or load allowed
    input  logic                                 i_seed_load,  // load seed, wins over step
    input  logic [WIDTH-1:0]                     i_seed_data,
    input  logic [TAP_COUNT*TAP_INDEX_WIDTH-1:0] i_taps,       // packed 1-based positions
    output logic [WIDTH-1:0]                     o_lfsr_out,
    output logic                                 ow_lfsr_done  // register back at seed
);

    logic [WIDTH-1:0] r_lfsr;
    logic [WIDTH-1:0] w_mask;      // one-hot per used tap
    logic             w_feedback;

    //////////////////////////////
    // tap positions to bit mask
    //////////////////////////////
    always_comb begin : tap_decode
        logic [TAP_INDEX_WIDTH-1:0] pos;
        w_mask = '0;
        for (int i = 0; i < TAP_COUNT; i++) begin
            pos = i_taps[i*TAP_INDEX_WIDTH +: TAP_INDEX_WIDTH];
            // zero slot is unused, out-of-range slot ignored
            if (pos != '0 && int'(pos) <= WIDTH) begin
                w_mask[int'(pos) - 1] = 1'b1;
            end
        end
    end

    // xnor of tapped bits, all-ones is the lockup state
    assign w_feedback = ~^(r_lfsr & w_mask);

    // full-width compare, so only a length equal to WIDTH returns here
    assign ow_lfsr_done = (r_lfsr == i_seed_data);

    //////////////////////////////
    // shift register
    //////////////////////////////
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            r_lfsr <= '0;
        end else if (i_enable) begin
            if (i_seed_load) begin
                r_lfsr <= i_seed_data;
            end else begin
                r_lfsr <= {r_lfsr[WIDTH-2:0], w_feedback};  // newest bit in bit 0
            end
        end
    end

    assign o_lfsr_out = r_lfsr;

endmodule : shifter_lfsr

// File: design/prbs_poly_rom.sv
`timescale 1ns/1ps

// polynomial select to length and packed xnor taps
module prbs_poly_rom #(
    parameter int WIDTH = 16  // longest register the entries may use
) (
    input  logic [prbs_pkg::POLY_SEL_W-1:0]                    i_poly_sel,
    output logic [prbs_pkg::TAP_COUNT*prbs_pkg::TAP_INDEX_W-1:0] o_taps,
    output logic [4:0]                                         o_len
);
    import prbs_pkg::*;

    localparam int TAPS_W = TAP_COUNT * TAP_INDEX_W;
    localparam int N_POLY = 2 ** POLY_SEL_W;

    function automatic logic [4:0] len_of(input int sel);
        case (sel)
            0:       len_of = 5'd3;
            1:       len_of = 5'd4;
            2:       len_of = 5'd5;
            3:       len_of = 5'd6;
            4:       len_of = 5'd7;
            5:       len_of = 5'd8;
            6:       len_of = 5'd12;
            default: len_of = 5'd16;
        endcase
    endfunction

    // slot 0 sits in the low bits
    function automatic logic [TAPS_W-1:0] pack_taps(input int t0, input int t1,
                                                    input int t2, input int t3);
        pack_taps = {TAP_INDEX_W'(t3), TAP_INDEX_W'(t2), TAP_INDEX_W'(t1), TAP_INDEX_W'(t0)};
    endfunction

    function automatic logic [TAPS_W-1:0] taps_of(input int sel);
        case (sel)
            0:       taps_of = pack_taps(3, 2, 0, 0);
            1:       taps_of = pack_taps(4, 3, 0, 0);
            2:       taps_of = pack_taps(5, 3, 0, 0);
            3:       taps_of = pack_taps(6, 5, 0, 0);
            4:       taps_of = pack_taps(7, 6, 0, 0);
            5:       taps_of = pack_taps(8, 6, 5, 4);
            6:       taps_of = pack_taps(12, 6, 4, 1);
            default: taps_of = pack_taps(16, 15, 13, 4);
        endcase
    endfunction

    // last entry that still fits the register, lengths rise with select
    function automatic int fit_sel();
        int best;
        best = 0;
        for (int s = 0; s < N_POLY; s++) begin
            if (int'(len_of(s)) <= WIDTH) best = s;
        end
        return best;
    endfunction

    localparam int FIT_SEL = fit_sel();

    always_comb begin : rom_lookup
        int eff_sel;
        eff_sel = int'(i_poly_sel);
        if (int'(len_of(eff_sel)) > WIDTH) eff_sel = FIT_SEL;  // too long, fall back
        o_len  = len_of(eff_sel);
        o_taps = taps_of(eff_sel);
    end

endmodule : prbs_poly_rom

// File: design/prbs_checker.sv
`timescale 1ns/1ps

// self-synchronizing serial prbs checker
module prbs_checker #(
    parameter int WIDTH = 16  // history depth
) (
    input  logic                                               i_clk,
    input  logic                                               i_rst_n,
    input  logic                                               i_clear,     // drop sync and count
    input  logic                                               i_rx_valid,  // bit present
    input  logic                                               i_rx_bit,
    input  logic [prbs_pkg::TAP_COUNT*prbs_pkg::TAP_INDEX_W-1:0] i_taps,
    input  logic [4:0]                                         i_len,       // bits to fill
    output logic                                               o_sync,
    output logic                                               o_err,
    output logic [prbs_pkg::ERR_CNT_W-1:0]                     o_err_count
);
    import prbs_pkg::*;

    logic [WIDTH-1:0]     r_hist;     // received bits, bit 0 newest
    logic [WIDTH-1:0]     w_mask;
    logic                 w_pred;     // expected next bit
    logic                 w_miss;     // valid bit differs from prediction
    logic [4:0]           r_fill;     // valid bits since reset or clear
    logic                 r_sync;
    logic                 r_err;
    logic [ERR_CNT_W-1:0] r_err_cnt;

    //////////////////////////////
    // prediction
    //////////////////////////////
    always_comb begin : tap_decode
        logic [TAP_INDEX_W-1:0] pos;
        w_mask = '0;
        for (int i = 0; i < TAP_COUNT; i++) begin
            pos = i_taps[i*TAP_INDEX_W +: TAP_INDEX_W];
            if (pos != '0 && int'(pos) <= WIDTH) begin
                w_mask[int'(pos) - 1] = 1'b1;
            end
        end
    end

    // same recurrence as the generator, run on what was received
    assign w_pred = ~^(r_hist & w_mask);
    assign w_miss = i_rx_valid && (i_rx_bit != w_pred);

    // the received bit goes in even when wrong, so one flip hits
    // once directly and once per tap as it moves through history
    always_ff @(posedge i_clk) begin
        if (i_rx_valid) begin
            r_hist <= {r_hist[WIDTH-2:0], i_rx_bit};
        end
    end

    //////////////////////////////
    // sync, error pulse, count
    //////////////////////////////
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            r_fill    <= '0;
            r_sync    <= 1'b0;
            r_err     <= 1'b0;
            r_err_cnt <= '0;
        end else if (i_clear) begin
            r_fill    <= '0;
            r_sync    <= 1'b0;
            r_err     <= 1'b0;
            r_err_cnt <= '0;
        end else begin
            r_err <= r_sync && w_miss;  // only trusted once history is full

            // fill until i_len bits are in, then hold
            if (i_rx_valid && !r_sync) begin
                r_fill <= r_fill + 5'd1;
                if (r_fill + 5'd1 >= i_len) begin
                    r_sync <= 1'b1;
                end
            end

            if (r_sync && w_miss && r_err_cnt != '1) begin
                r_err_cnt <= r_err_cnt + 1'b1;  // saturates at all ones
            end
        end
    end

    assign o_sync      = r_sync;
    assign o_err       = r_err;
    assign o_err_count = r_err_cnt;

endmodule : prbs_checker

// File: design/prbs_period_meter.sv
`timescale 1ns/1ps

// steps between successive generator wraps
module prbs_period_meter (
    input  logic                          i_clk,
    input  logic                          i_rst_n,
    input  logic                          i_restart,  // new seed loaded
    input  logic                          i_step,     // generator advanced this clock
    input  logic                          i_wrap,     // generator at seed
    output logic [prbs_pkg::PERIOD_W-1:0] o_period,
    output logic                          o_period_valid
);
    import prbs_pkg::*;

    logic [PERIOD_W-1:0] r_count;   // steps since last wrap
    logic [PERIOD_W-1:0] r_period;
    logic                r_armed;   // first wrap seen
    logic                r_valid;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            r_count  <= '0;
            r_period <= '0;
            r_armed  <= 1'b0;
            r_valid  <= 1'b0;
        end else if (i_restart) begin
            r_count  <= '0;
            r_period <= '0;
            r_armed  <= 1'b0;
            r_valid  <= 1'b0;
        end else if (i_step) begin
            if (i_wrap) begin
                // leaving the seed again, one full period done
                if (r_armed) begin
                    r_period <= r_count;
                    r_valid  <= 1'b1;
                end
                r_armed <= 1'b1;
                r_count <= {{(PERIOD_W-1){1'b0}}, 1'b1};  // this step counts
            end else if (r_armed && r_count != '1) begin
                r_count <= r_count + 1'b1;  // short lengths never wrap, hold at max
            end
        end
    end

    assign o_period       = r_period;
    assign o_period_valid = r_valid;

endmodule : prbs_period_meter

// File: design/prbs_link_top.sv
`timescale 1ns/1ps

// prbs link tester top
module prbs_link_top #(
    parameter int WIDTH = 16  // generator and checker register width
) (
    input  logic                            i_clk,
    input  logic                            i_rst_n,
    input  logic                            i_run,       // level, generator steps
    input  logic                            i_load,      // pulse, load seed
    input  logic [WIDTH-1:0]                i_seed,
    input  logic [prbs_pkg::POLY_SEL_W-1:0] i_poly_sel,
    input  logic                            i_inject,    // pulse, flip one tx bit
    input  logic                            i_clear,     // pulse, reset checker
    output logic                            o_tx_bit,
    output logic                            o_sync,
    output logic                            o_err,
    output logic [prbs_pkg::ERR_CNT_W-1:0]  o_err_count,
    output logic [prbs_pkg::PERIOD_W-1:0]   o_period,
    output logic                            o_period_valid
);
    import prbs_pkg::*;

    logic [TAP_COUNT*TAP_INDEX_W-1:0] w_taps;
    logic [4:0]                       w_len;
    logic [WIDTH-1:0]                 w_lfsr;
    logic                             w_wrap;
    logic                             w_gen_en;    // load works while stopped
    logic                             w_step;
    logic                             r_tx_bit;    // channel stage
    logic                             r_rx_valid;  // i_run, one clock late

    assign w_gen_en = i_run | i_load;
    assign w_step   = i_run & ~i_load;

    prbs_poly_rom #(.WIDTH(WIDTH)) u_rom (
        .i_poly_sel (i_poly_sel),
        .o_taps     (w_taps),
        .o_len      (w_len)
    );

    shifter_lfsr #(
        .WIDTH           (WIDTH),
        .TAP_INDEX_WIDTH (TAP_INDEX_W),
        .TAP_COUNT       (TAP_COUNT)
    ) u_gen (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_enable     (w_gen_en),
        .i_seed_load  (i_load),
        .i_seed_data  (i_seed),
        .i_taps       (w_taps),
        .o_lfsr_out   (w_lfsr),
        .ow_lfsr_done (w_wrap)
    );

    //////////////////////////////
    // injector and channel
    //////////////////////////////
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            r_tx_bit   <= 1'b0;
            r_rx_valid <= 1'b0;
        end else begin
            r_tx_bit   <= w_lfsr[0] ^ i_inject;  // newest bit, maybe flipped
            r_rx_valid <= i_run;                 // lines up with the captured bit
        end
    end

    prbs_checker #(.WIDTH(WIDTH)) u_chk (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_clear     (i_clear),
        .i_rx_valid  (r_rx_valid),
        .i_rx_bit    (r_tx_bit),
        .i_taps      (w_taps),
        .i_len       (w_len),
        .o_sync      (o_sync),
        .o_err       (o_err),
        .o_err_count (o_err_count)
    );

    prbs_period_meter u_meter (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_restart      (i_load),
        .i_step         (w_step),
        .i_wrap         (w_wrap),
        .o_period       (o_period),
        .o_period_valid (o_period_valid)
    );

    assign o_tx_bit = r_tx_bit;

endmodule : prbs_link_top

// File: tb/prbs_link_monitor.sv
`timescale 1ns/1ps

// bit model of the link and output checks
module prbs_link_monitor #(
    parameter int WIDTH = 16
) (
    input  logic                            i_clk,
    input  logic                            i_rst_n,
    input  logic                            i_run,
    input  logic                            i_load,
    input  logic [WIDTH-1:0]                i_seed,
    input  logic [prbs_pkg::POLY_SEL_W-1:0] i_poly_sel,
    input  logic                            i_inject,
    input  logic                            i_clear,
    input  logic                            i_row_done,    // row finished, check totals
    input  int                              i_row_idx,
    input  logic [prbs_pkg::ERR_CNT_W-1:0]  i_exp_err,
    input  logic                            i_exp_period,
    input  logic                            i_tx_bit,
    input  logic                            i_sync,
    input  logic                            i_err,
    input  logic [prbs_pkg::ERR_CNT_W-1:0]  i_err_count,
    input  logic [prbs_pkg::PERIOD_W-1:0]   i_period,
    input  logic                            i_period_valid,
    output int                              o_rows_passed,
    output int                              o_rows_failed,
    output int                              o_check_fails
);
    import prbs_pkg::*;

    logic [WIDTH-1:0] m_reg;         // generator model
    logic             m_tx;          // channel stage model
    logic             m_rx_valid;
    int               m_fill;        // valid bits since clear
    int               m_sel;
    logic             m_clear_seen;
    logic             m_done_seen;

    int rows_passed = 0;
    int rows_failed = 0;
    int check_fails = 0;
    int row_fails   = 0;
    int tx_miss     = 0;  // only the first miss of a row is printed
    int sync_miss   = 0;
    int err_pulses  = 0;

    // maximal-length lengths per select
    function automatic int len_of(input int sel);
        case (sel)
            0:       return 3;
            1:       return 4;
            2:       return 5;
            3:       return 6;
            4:       return 7;
            5:       return 8;
            6:       return 12;
            default: return 16;
        endcase
    endfunction

    function automatic logic [WIDTH-1:0] tap_mask(input int sel);
        int               t [4];
        logic [WIDTH-1:0] m;
        case (sel)
            0:       t = '{3, 2, 0, 0};
            1:       t = '{4, 3, 0, 0};
            2:       t = '{5, 3, 0, 0};
            3:       t = '{6, 5, 0, 0};
            4:       t = '{7, 6, 0, 0};
            5:       t = '{8, 6, 5, 4};
            6:       t = '{12, 6, 4, 1};
            default: t = '{16, 15, 13, 4};
        endcase
        m = '0;
        for (int i = 0; i < 4; i++) begin
            if (t[i] > 0 && t[i] <= WIDTH) m[t[i]-1] = 1'b1;  // 1-based position
        end
        return m;
    endfunction

    task automatic report_err(input string msg);
        $display("ERR %0t: %s", $time, msg);
        check_fails++;
        row_fails++;
    endtask

    //////////////////////////////
    // model, advanced on rising edge
    //////////////////////////////
    always @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            m_reg        <= '0;
            m_tx         <= 1'b0;
            m_rx_valid   <= 1'b0;
            m_fill       <= 0;
            m_sel        <= 0;
            m_clear_seen <= 1'b0;
            m_done_seen  <= 1'b0;
        end else begin
            m_sel        <= int'(i_poly_sel);
            m_clear_seen <= i_clear;
            m_done_seen  <= i_row_done;
            m_rx_valid   <= i_run;
            m_tx         <= m_reg[0] ^ i_inject;  // newest bit, flipped on inject
            if (i_load) begin
                m_reg <= i_seed;
            end else if (i_run) begin
                m_reg <= {m_reg[WIDTH-2:0], ~^(m_reg & tap_mask(int'(i_poly_sel)))};
            end
            if (i_clear) begin
                m_fill <= 0;
            end else if (m_rx_valid && m_fill < 1000) begin
                m_fill <= m_fill + 1;
            end
        end
    end

    task automatic finish_row();
        int full;
        full = (1 << len_of(m_sel)) - 1;
        if (i_err_count != i_exp_err)
            report_err($sformatf("error count %0d, expected %0d", i_err_count, i_exp_err));
        if (err_pulses != int'(i_exp_err))
            report_err($sformatf("%0d error pulses, expected %0d", err_pulses, i_exp_err));
        if (i_exp_period) begin
            if (!i_period_valid)
                report_err("period valid still low after two wraps");
            else if (int'(i_period) != full)
                report_err($sformatf("period %0d, expected %0d", i_period, full));
        end else if (i_period_valid) begin
            report_err("period valid set for a length below the register width");
        end
        if (row_fails == 0) rows_passed++;
        else rows_failed++;
        $display("row %0d sel %0d len %0d: %0d error pulses, %s", i_row_idx, m_sel,
                 len_of(m_sel), err_pulses, (row_fails == 0) ? "pass" : "fail");
    endtask

    //////////////////////////////
    // compare on falling edge
    //////////////////////////////
    always @(negedge i_clk) begin : compare
        logic exp_sync;
        exp_sync = (m_fill >= len_of(m_sel));
        if (!i_rst_n) begin
            if (i_err || i_sync || i_period_valid || i_tx_bit)
                report_err("outputs not idle during reset");
        end else begin
            if (m_clear_seen) begin
                row_fails  = 0;   // new row starts at the clear
                tx_miss    = 0;
                sync_miss  = 0;
                err_pulses = 0;
                if (i_sync || i_err || i_err_count != '0)
                    report_err("clear left sync or error count set");
            end
            if (i_tx_bit !== m_tx) begin
                if (tx_miss == 0)
                    report_err($sformatf("tx bit %b, model %b", i_tx_bit, m_tx));
                tx_miss++;
            end
            if (i_sync !== exp_sync) begin
                if (sync_miss == 0)
                    report_err($sformatf("sync %b after %0d bits, expected %b",
                                         i_sync, m_fill, exp_sync));
                sync_miss++;
            end
            if (i_err === 1'b1) err_pulses++;
            if (m_done_seen) finish_row();
        end
    end

    assign o_rows_passed = rows_passed;
    assign o_rows_failed = rows_failed;
    assign o_check_fails = check_fails;

endmodule : prbs_link_monitor

// File: tb/prbs_link_tb.sv
`timescale 1ns/1ps

// testbench top for the prbs link tester
module prbs_link_tb;
    import prbs_pkg::*;

    localparam int WIDTH  = 16;
    localparam int N_ROWS = 12;

    logic                  clk = 1'b0;
    logic                  rst_n;
    logic                  run;
    logic                  load;
    logic [WIDTH-1:0]      seed;
    logic [POLY_SEL_W-1:0] poly_sel;
    logic                  inject;
    logic                  clear;
    logic                  tx_bit;
    logic                  sync;
    logic                  err;
    logic [ERR_CNT_W-1:0]  err_count;
    logic [PERIOD_W-1:0]   period;
    logic                  period_valid;

    // row context handed to the monitor
    logic                  row_done;
    int                    row_idx;
    logic [ERR_CNT_W-1:0]  exp_err;
    logic                  exp_period;
    int                    rows_passed;
    int                    rows_failed;
    int                    check_fails;

    // stimulus table, one entry per row
    int               sel_tab  [N_ROWS];
    logic [WIDTH-1:0] seed_tab [N_ROWS];
    int               run_tab  [N_ROWS];
    int               inj0_tab [N_ROWS];  // run cycle of first flip, 0 = none
    int               inj1_tab [N_ROWS];
    int               err_tab  [N_ROWS];  // 1 + taps per flip
    bit               per_tab  [N_ROWS];
    int               n_rows = 0;

    int cycle_cnt   = 0;
    int cycle_limit = 0;   // 0 until the table is built
    int rnd;

    always #20 clk = ~clk;  // 40 ns period

    prbs_link_top #(.WIDTH(WIDTH)) dut_i (
        .i_clk          (clk),
        .i_rst_n        (rst_n),
        .i_run          (run),
        .i_load         (load),
        .i_seed         (seed),
        .i_poly_sel     (poly_sel),
        .i_inject       (inject),
        .i_clear        (clear),
        .o_tx_bit       (tx_bit),
        .o_sync         (sync),
        .o_err          (err),
        .o_err_count    (err_count),
        .o_period       (period),
        .o_period_valid (period_valid)
    );

    prbs_link_monitor #(.WIDTH(WIDTH)) mon_i (
        .i_clk          (clk),
        .i_rst_n        (rst_n),
        .i_run          (run),
        .i_load         (load),
        .i_seed         (seed),
        .i_poly_sel     (poly_sel),
        .i_inject       (inject),
        .i_clear        (clear),
        .i_row_done     (row_done),
        .i_row_idx      (row_idx),
        .i_exp_err      (exp_err),
        .i_exp_period   (exp_period),
        .i_tx_bit       (tx_bit),
        .i_sync         (sync),
        .i_err          (err),
        .i_err_count    (err_count),
        .i_period       (period),
        .i_period_valid (period_valid),
        .o_rows_passed  (rows_passed),
        .o_rows_failed  (rows_failed),
        .o_check_fails  (check_fails)
    );

    //////////////////////////////
    // run limit
    //////////////////////////////
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
            $display("timeout: the run went past %0d cycles without finishing", cycle_limit);
            $display("Test FAILED");
            $finish;
        end
    end

    task automatic add_row(input int sel, input logic [WIDTH-1:0] sd, input int cycles,
                           input int inj0, input int inj1, input int errs, input bit per);
        sel_tab[n_rows]  = sel;
        seed_tab[n_rows] = sd;
        run_tab[n_rows]  = cycles;
        inj0_tab[n_rows] = inj0;
        inj1_tab[n_rows] = inj1;
        err_tab[n_rows]  = errs;
        per_tab[n_rows]  = per;
        n_rows++;
    endtask

    // clean run from a drawn seed, bit 0 cleared so the lockup state can't occur
    task automatic add_random_row(input int sel, input int cycles);
        logic [WIDTH-1:0] sd;
        rnd   = $urandom;
        sd    = rnd[WIDTH-1:0];
        sd[0] = 1'b0;
        add_row(sel, sd, cycles, 0, 0, 0, 1'b0);
    endtask

    task automatic build_table();
        add_row(0, 16'h0000,    60,    0,     0,  0, 1'b0);  // clean, no period at length 3
        add_row(1, 16'h0005,   120,   20,    70,  6, 1'b0);
        add_row(2, 16'h0012,   120,   20,    70,  6, 1'b0);
        add_row(3, 16'h0021,   150,   30,    90,  6, 1'b0);
        add_row(4, 16'h0040,   150,   30,    90,  6, 1'b0);
        add_row(5, 16'h00A5,   200,   40,   120, 10, 1'b0);  // four taps
        add_row(6, 16'h0ACE,   250,   50,   150, 10, 1'b0);
        add_row(7, 16'hACE1, 65600, 1000, 30000, 10, 1'b1);  // two full wraps
        add_row(0, 16'h0003,    40,   10,     0,  3, 1'b0);  // count cleared from row 7
        add_random_row(1, 200);
        add_random_row(5, 200);
        add_random_row(6, 200);
    endtask

    function automatic int total_run();
        int sum;
        sum = 0;
        for (int r = 0; r < N_ROWS; r++) begin
            sum += run_tab[r];
        end
        return sum;
    endfunction

    // load, clear, run with flips, then hand the row to the monitor
    task automatic run_row(input int r);
        row_idx    = r;
        exp_err    = ERR_CNT_W'(err_tab[r]);
        exp_period = per_tab[r];
        poly_sel   = POLY_SEL_W'(sel_tab[r]);
        seed       = seed_tab[r];
        load       = 1'b1;
        @(negedge clk);
        load  = 1'b0;
        clear = 1'b1;
        @(negedge clk);
        clear = 1'b0;
        run   = 1'b1;
        for (int c = 0; c < run_tab[r]; c++) begin
            inject = (inj0_tab[r] > 0 && c == inj0_tab[r]) ||
                     (inj1_tab[r] > 0 && c == inj1_tab[r]);
            @(negedge clk);
        end
        run    = 1'b0;
        inject = 1'b0;
        @(negedge clk);    // last bit through checker
        row_done = 1'b1;
        @(negedge clk);
        row_done = 1'b0;
        while (rows_passed + rows_failed < r + 1) begin
            @(posedge clk);
        end
        @(negedge clk);
    endtask

    //////////////////////////////
    // main sequence
    //////////////////////////////
    initial begin
        rst_n      = 1'b0;
        run        = 1'b0;
        load       = 1'b0;
        seed       = '0;
        poly_sel   = '0;
        inject     = 1'b0;
        clear      = 1'b0;
        row_done   = 1'b0;
        row_idx    = 0;
        exp_err    = '0;
        exp_period = 1'b0;
        rnd        = $urandom(32'h7674);
        build_table();
        cycle_limit = total_run() + 1000;
        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        for (int r = 0; r < N_ROWS; r++) begin
            run_row(r);
        end
        $display("rows %0d, passed %0d, failed %0d, check failures %0d",
                 N_ROWS, rows_passed, rows_failed, check_fails);
        if (rows_failed == 0 && check_fails == 0 && rows_passed == N_ROWS) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule : prbs_link_tb

// File: sim.f
design/prbs_pkg.sv
design/shifter_lfsr.sv
design/prbs_poly_rom.sv
design/prbs_checker.sv
design/prbs_period_meter.sv
design/prbs_link_top.sv
tb/prbs_link_monitor.sv
tb/prbs_link_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the prbs link testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
    --top-module prbs_link_tb \
    -f sim.f \
    -o prbs_sim

./obj_dir/prbs_sim | tee sim.log

if grep -q "Test FAILED" sim.log; then
    echo "simulation reported a failure, see sim.log"
    exit 1
fi

echo "simulation finished without failures"
